// ==== include/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// RV64I datapath width
`define XLEN      64

// Integer register file
`define REG_AW    5
`define REG_COUNT 32

`endif

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // ####################
    // Major opcodes
    // ####################

    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,  // R-type ALU
        OP_IMM = 7'b0010011,  // I-type ALU
        OP_LUI = 7'b0110111
    } opcode_e;

    // ####################
    // funct3 codes
    // ####################

    localparam logic [2:0] F3_ADD = 3'b000;  // Also SUB and ADDI
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // ####################
    // funct7 codes
    // ####################

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB

endpackage

// ==== source/pipe_pkg.sv ====
`include "rv_defines.svh"

package pipe_pkg;

    // ####################
    // ALU operations
    // ####################

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_PASS2 = 4'd7   // op2 straight through, LUI
    } alu_op_e;

    // ####################
    // Writeback bundle
    // ####################

    // Execute result headed for the register file, also the bypass path
    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wb_t;

endpackage

// ==== source/id_ex_if.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

interface id_ex_if;

    logic                 valid;
    logic [`XLEN-1:0]     pc;
    logic [31:0]          inst;
    logic [`XLEN-1:0]     op1;
    logic [`XLEN-1:0]     op2;
    pipe_pkg::alu_op_e    alu_op;
    logic                 reg_we;
    logic [`REG_AW-1:0]   rd;
    logic                 illegal;
    logic                 stall;     // Back pressure from execute

    modport producer (
        output valid, pc, inst, op1, op2, alu_op, reg_we, rd, illegal,
        input  stall
    );

    modport consumer (
        input  valid, pc, inst, op1, op2, alu_op, reg_we, rd, illegal,
        output stall
    );

endinterface

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [`XLEN-1:0]    wb_adr_i,
    input  logic [31:0]         wb_dat_i,
    output logic                wb_ack_o,
    input  pipe_pkg::wb_t       fwd_i,
    id_ex_if.producer           id_o
);

    logic                 ack_q;
    logic                 pend_q;        // Accepted, blocked by stall
    logic [`XLEN-1:0]     pend_pc_q;
    logic [31:0]          pend_inst_q;
    logic [`XLEN-1:0]     regs_q [`REG_COUNT];

    logic [31:0]          inst;
    logic [`XLEN-1:0]     pc;
    rv_isa_pkg::opcode_e  opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`XLEN-1:0]     rs1_val;
    logic [`XLEN-1:0]     rs2_val;
    logic [`XLEN-1:0]     op2;
    pipe_pkg::alu_op_e    alu_op;
    logic                 reg_we;
    logic                 illegal;

    // ####################
    // Wishbone slave
    // ####################

    always_ff @(posedge clk) begin
        if (rst_n) begin
            ack_q  <= 1'b0;
            pend_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i && wb_stb_i && wb_we_i && !ack_q && !pend_q && !id_o.stall;
            if (ack_q && id_o.stall)
                pend_q <= 1'b1;
            else if (!id_o.stall)
                pend_q <= 1'b0;
        end
    end

    // Master still drives adr/dat during the ack cycle
    always_ff @(posedge clk) begin
        if (ack_q) begin
            pend_pc_q   <= wb_adr_i;
            pend_inst_q <= wb_dat_i;
        end
    end

    assign wb_ack_o = ack_q;
    assign inst     = pend_q ? pend_inst_q : wb_dat_i;
    assign pc       = pend_q ? pend_pc_q : wb_adr_i;

    // ####################
    // Register file
    // ####################

    // Bypass from ID/EX beats the array
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (fwd_i.we && fwd_i.rd == addr)
            return fwd_i.data;
        return regs_q[addr];
    endfunction

    assign rs1_val = read_reg(inst[19:15]);
    assign rs2_val = read_reg(inst[24:20]);

    // Same edge as the execute result register
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs_q[i] <= '0;
        end else if (fwd_i.we && !id_o.stall) begin
            regs_q[fwd_i.rd] <= fwd_i.data;
        end
    end

    // ####################
    // Decoder
    // ####################

    assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        alu_op  = pipe_pkg::ALU_ADD;
        op2     = rs2_val;
        reg_we  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            rv_isa_pkg::OP_REG: begin
                reg_we = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD: begin
                        if (funct7 == rv_isa_pkg::F7_ALT)
                            alu_op = pipe_pkg::ALU_SUB;
                        else if (funct7 != rv_isa_pkg::F7_BASE)
                            illegal = 1'b1;
                    end
                    rv_isa_pkg::F3_SLL: alu_op = pipe_pkg::ALU_SLL;
                    rv_isa_pkg::F3_XOR: alu_op = pipe_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL: alu_op = pipe_pkg::ALU_SRL;
                    rv_isa_pkg::F3_OR:  alu_op = pipe_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: alu_op = pipe_pkg::ALU_AND;
                    default:            illegal = 1'b1;  // SLT, SLTU
                endcase
                // SRA and friends
                if (funct3 != rv_isa_pkg::F3_ADD && funct7 != rv_isa_pkg::F7_BASE)
                    illegal = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                reg_we  = 1'b1;
                op2     = {{(`XLEN-12){inst[31]}}, inst[31:20]};
                illegal = (funct3 != rv_isa_pkg::F3_ADD);  // ADDI only
            end
            rv_isa_pkg::OP_LUI: begin
                reg_we = 1'b1;
                alu_op = pipe_pkg::ALU_PASS2;
                op2    = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'h000};
            end
            default: illegal = 1'b1;
        endcase
        if (illegal)
            reg_we = 1'b0;
    end

    assign id_o.valid   = ack_q || pend_q;
    assign id_o.pc      = pc;
    assign id_o.inst    = inst;
    assign id_o.op1     = rs1_val;
    assign id_o.op2     = op2;
    assign id_o.alu_op  = alu_op;
    assign id_o.reg_we  = reg_we;
    assign id_o.rd      = inst[11:7];
    assign id_o.illegal = illegal;

    ack_single_a: assert property (@(posedge clk) disable iff (rst_n)
        wb_ack_o |=> !wb_ack_o);

endmodule

// ==== source/id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg (
    input  logic          clk,
    input  logic          rst_n,
    id_ex_if.consumer     in_i,
    id_ex_if.producer     out_o
);

    // Stall from execute also freezes decode
    assign in_i.stall = out_o.stall;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            out_o.valid   <= 1'b0;
            out_o.pc      <= '0;
            out_o.inst    <= '0;
            out_o.op1     <= '0;
            out_o.op2     <= '0;
            out_o.alu_op  <= pipe_pkg::ALU_ADD;
            out_o.reg_we  <= 1'b0;
            out_o.rd      <= '0;
            out_o.illegal <= 1'b0;
        end else if (!out_o.stall) begin
            out_o.valid   <= in_i.valid;    // High only on ack or pending
            out_o.pc      <= in_i.pc;
            out_o.inst    <= in_i.inst;
            out_o.op1     <= in_i.op1;
            out_o.op2     <= in_i.op2;
            out_o.alu_op  <= in_i.alu_op;
            out_o.reg_we  <= in_i.reg_we;
            out_o.rd      <= in_i.rd;
            out_o.illegal <= in_i.illegal;
        end
    end

    // ####################
    // Checks
    // ####################

    // A held bundle must reach execute untouched
    bundle_hold_a: assert property (@(posedge clk) disable iff (rst_n)
        out_o.valid && out_o.stall |=>
            out_o.valid && $stable(out_o.pc) && $stable(out_o.inst) &&
            $stable(out_o.op1) && $stable(out_o.op2) && $stable(out_o.rd) &&
            $stable(out_o.alu_op) && $stable(out_o.reg_we) && $stable(out_o.illegal));

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    id_ex_if.consumer              id_i,
    output pipe_pkg::wb_t          fwd_o,
    output logic                   res_valid_o,
    output logic [`REG_AW-1:0]     res_rd_o,
    output logic [`XLEN-1:0]       res_data_o,
    output logic                   res_illegal_o,
    input  logic                   res_ready_i
);

    logic [`XLEN-1:0]     alu_res;
    logic [5:0]           shamt;
    logic                 stall;

    logic                 res_valid_q;
    logic [`REG_AW-1:0]   res_rd_q;
    logic [`XLEN-1:0]     res_data_q;
    logic                 res_illegal_q;

    // ####################
    // ALU
    // ####################

    assign shamt = id_i.op2[5:0];  // RV64 shift amount

    always_comb begin
        case (id_i.alu_op)
            pipe_pkg::ALU_ADD:   alu_res = id_i.op1 + id_i.op2;
            pipe_pkg::ALU_SUB:   alu_res = id_i.op1 - id_i.op2;
            pipe_pkg::ALU_AND:   alu_res = id_i.op1 & id_i.op2;
            pipe_pkg::ALU_OR:    alu_res = id_i.op1 | id_i.op2;
            pipe_pkg::ALU_XOR:   alu_res = id_i.op1 ^ id_i.op2;
            pipe_pkg::ALU_SLL:   alu_res = id_i.op1 << shamt;
            pipe_pkg::ALU_SRL:   alu_res = id_i.op1 >> shamt;
            pipe_pkg::ALU_PASS2: alu_res = id_i.op2;
            default:             alu_res = '0;
        endcase
    end

    // Bypass and register file write, x0 never written
    assign fwd_o = '{we:   id_i.valid && id_i.reg_we && (id_i.rd != '0),
                     rd:   id_i.rd,
                     data: alu_res};

    // ####################
    // Result register
    // ####################

    // Full and not taken
    assign stall      = res_valid_q && !res_ready_i;
    assign id_i.stall = stall;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            res_valid_q   <= 1'b0;
            res_rd_q      <= '0;
            res_data_q    <= '0;
            res_illegal_q <= 1'b0;
        end else if (!stall) begin
            res_valid_q   <= id_i.valid;
            res_rd_q      <= id_i.rd;
            res_data_q    <= alu_res;
            res_illegal_q <= id_i.illegal;
        end
    end

    assign res_valid_o   = res_valid_q;
    assign res_rd_o      = res_rd_q;
    assign res_data_o    = res_data_q;
    assign res_illegal_o = res_illegal_q;

    // Result stays put until the sink takes it
    res_keep_a: assert property (@(posedge clk) disable iff (rst_n)
        res_valid_o && !res_ready_i |=>
            res_valid_o && $stable(res_rd_o) && $stable(res_data_o));

endmodule

// ==== source/core_top.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module core_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // Instruction port, Wishbone classic slave
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`XLEN-1:0]       wb_adr_i,   // PC
    input  logic [31:0]            wb_dat_i,   // Instruction
    output logic                   wb_ack_o,

    // Result stream
    output logic                   res_valid_o,
    output logic [`REG_AW-1:0]     res_rd_o,
    output logic [`XLEN-1:0]       res_data_o,
    output logic                   res_illegal_o,
    input  logic                   res_ready_i
);

    pipe_pkg::wb_t fwd;

    id_ex_if dec_if ();
    id_ex_if exe_if ();

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .fwd_i    (fwd),
        .id_o     (dec_if.producer)
    );

    id_ex_reg u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .in_i  (dec_if.consumer),
        .out_o (exe_if.producer)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_i          (exe_if.consumer),
        .fwd_o         (fwd),
        .res_valid_o   (res_valid_o),
        .res_rd_o      (res_rd_o),
        .res_data_o    (res_data_o),
        .res_illegal_o (res_illegal_o),
        .res_ready_i   (res_ready_i)
    );

endmodule

// ==== test/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 2;  // 4 ns period

    initial begin
        clk_o = 1'b0;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_top;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ENTRIES  = 28;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_ENTRIES * 40) * CLK_PERIOD;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc_i;
    logic                 wb_stb_i;
    logic                 wb_we_i;
    logic [`XLEN-1:0]     wb_adr_i;
    logic [31:0]          wb_dat_i;
    logic                 wb_ack_o;
    logic                 res_valid_o;
    logic [`REG_AW-1:0]   res_rd_o;
    logic [`XLEN-1:0]     res_data_o;
    logic                 res_illegal_o;
    logic                 res_ready_i;

    // Stimulus table, one Wishbone write per entry
    logic [31:0]          prog_inst [NUM_ENTRIES];
    bit                   prog_rand [NUM_ENTRIES];  // Random back pressure
    bit                   prog_ill  [NUM_ENTRIES];  // Expected illegal flag
    int                   prog_len;

    logic [`XLEN-1:0]     reg_model [`REG_COUNT];
    logic [`REG_AW-1:0]   exp_rd_q [$];
    logic [`XLEN-1:0]     exp_data_q [$];
    bit                   exp_ill_q [$];
    int                   checked_count;
    bit                   rand_mode;
    logic [15:0]          lfsr_q;

    clk_gen u_clk (.clk_o(clk));

    core_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_o      (wb_ack_o),
        .res_valid_o   (res_valid_o),
        .res_rd_o      (res_rd_o),
        .res_data_o    (res_data_o),
        .res_illegal_o (res_illegal_o),
        .res_ready_i   (res_ready_i)
    );

    // ####################
    // Helpers
    // ####################

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic stop_failed;
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_failed();
        end
    endtask

    task automatic add_entry(input logic [31:0] inst, input bit rnd, input bit ill);
        if (prog_len >= NUM_ENTRIES) begin
            $display("Stimulus table has more entries than it can hold");
            stop_failed();
        end
        prog_inst[prog_len] = inst;
        prog_rand[prog_len] = rnd;
        prog_ill[prog_len]  = ill;
        prog_len++;
    endtask

    // ####################
    // Reference model
    // ####################

    task automatic model_step(input logic [31:0] inst, input bit ill);
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`XLEN-1:0]   res;
        logic [`REG_AW-1:0] rd;
        a   = reg_model[inst[19:15]];
        b   = reg_model[inst[24:20]];
        rd  = inst[11:7];
        res = '0;
        if (!ill) begin
            case (inst[6:0])
                7'b0110011: begin
                    case (inst[14:12])
                        3'b000:  res = inst[30] ? a - b : a + b;
                        3'b001:  res = a << b[5:0];
                        3'b100:  res = a ^ b;
                        3'b101:  res = a >> b[5:0];
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: res = a + {{52{inst[31]}}, inst[31:20]};
                7'b0110111: res = {{32{inst[31]}}, inst[31:12], 12'h000};
                default: begin
                    $display("Reference model cannot execute instruction 0x%h", inst);
                    stop_failed();
                end
            endcase
            if (rd != '0)
                reg_model[rd] = res;  // x0 stays zero
        end
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_ill_q.push_back(ill);
    endtask

    task automatic load_program;
        add_entry(enc_i(12'h123, 5'd0, 3'b000, 5'd1), 1'b0, 1'b0);
        add_entry(enc_i(12'hFFB, 5'd0, 3'b000, 5'd2), 1'b0, 1'b0);  // Negative immediate
        add_entry(enc_u(20'h80001, 5'd3), 1'b0, 1'b0);
        add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b0, 1'b0);
        add_entry(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 1'b0, 1'b0);
        add_entry(enc_r(7'h00, 5'd2, 5'd3, 3'b111, 5'd6), 1'b0, 1'b0);
        add_entry(enc_r(7'h00, 5'd3, 5'd1, 3'b110, 5'd7), 1'b0, 1'b0);
        add_entry(enc_r(7'h00, 5'd3, 5'd2, 3'b100, 5'd8), 1'b0, 1'b0);
        add_entry(enc_i(12'd36, 5'd0, 3'b000, 5'd9), 1'b0, 1'b0);
        add_entry(enc_r(7'h00, 5'd9, 5'd3, 3'b001, 5'd10), 1'b0, 1'b0);
        add_entry(enc_r(7'h00, 5'd9, 5'd2, 3'b101, 5'd11), 1'b0, 1'b0);
        // Dependent chain under back pressure
        add_entry(enc_r(7'h00, 5'd4, 5'd4, 3'b000, 5'd12), 1'b1, 1'b0);
        add_entry(enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd12), 1'b1, 1'b0);
        add_entry(enc_r(7'h20, 5'd1, 5'd12, 3'b000, 5'd13), 1'b1, 1'b0);
        add_entry(enc_r(7'h00, 5'd3, 5'd13, 3'b100, 5'd13), 1'b1, 1'b0);
        add_entry(enc_i(12'h055, 5'd1, 3'b000, 5'd0), 1'b1, 1'b0);   // Write to x0
        add_entry(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd14), 1'b1, 1'b0);
        add_entry({12'h000, 5'd2, 3'b010, 5'd1, 7'b0000011}, 1'b0, 1'b1);  // LW
        add_entry(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd15), 1'b0, 1'b0);
        add_entry(enc_r(7'h20, 5'd9, 5'd1, 3'b101, 5'd2), 1'b0, 1'b1);     // SRA
        add_entry(enc_r(7'h00, 5'd0, 5'd2, 3'b110, 5'd16), 1'b0, 1'b0);
        add_entry(enc_i(12'h001, 5'd17, 3'b000, 5'd17), 1'b1, 1'b0);
        add_entry(enc_i(12'h001, 5'd17, 3'b000, 5'd17), 1'b1, 1'b0);
        add_entry(enc_r(7'h00, 5'd10, 5'd17, 3'b000, 5'd18), 1'b1, 1'b0);
        add_entry(enc_r(7'h00, 5'd1, 5'd18, 3'b001, 5'd19), 1'b1, 1'b0);
        add_entry(enc_r(7'h00, 5'd9, 5'd19, 3'b101, 5'd20), 1'b1, 1'b0);
        add_entry(enc_r(7'h20, 5'd17, 5'd20, 3'b000, 5'd21), 1'b1, 1'b0);
        add_entry(enc_r(7'h00, 5'd21, 5'd21, 3'b111, 5'd22), 1'b1, 1'b0);
    endtask

    // ####################
    // Bus and monitor
    // ####################

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic wb_write(input logic [`XLEN-1:0] pc, input logic [31:0] inst);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = pc;
        wb_dat_i = inst;
        @(negedge clk);
        while (!wb_ack_o)
            @(negedge clk);
        @(negedge clk);  // Hold through the acceptance edge
    endtask

    task automatic check_result;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
        bit                 ill;
        if (exp_rd_q.size() == 0) begin
            $display("Result for x%0d arrived with no instruction outstanding", res_rd_o);
            stop_failed();
        end
        rd   = exp_rd_q.pop_front();
        data = exp_data_q.pop_front();
        ill  = exp_ill_q.pop_front();
        check_value("res_rd_o", 64'(res_rd_o), 64'(rd));
        check_value("res_illegal_o", 64'(res_illegal_o), 64'(ill));
        if (!ill)
            check_value("res_data_o", res_data_o, data);
        checked_count++;
    endtask

    // Ready changes on the falling edge, a transfer lands on the next rising edge
    initial begin
        res_ready_i = 1'b0;
        lfsr_q      = 16'd19;
        forever begin
            @(negedge clk);
            if (rand_mode) begin
                res_ready_i = lfsr_q[0];
                lfsr_q      = lfsr_next(lfsr_q);
            end else begin
                res_ready_i = 1'b1;
            end
            if (!rst_n && res_valid_o && res_ready_i)  // Out of reset
                check_result();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns with %0d of %0d results checked",
                 WATCHDOG_NS, checked_count, NUM_ENTRIES);
        stop_failed();
    end

    // ####################
    // Main sequence
    // ####################

    initial begin
        rst_n         = 1'b1;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        rand_mode     = 1'b0;
        checked_count = 0;
        prog_len      = 0;
        for (int i = 0; i < `REG_COUNT; i++)
            reg_model[i] = '0;
        load_program();
        if (prog_len != NUM_ENTRIES) begin
            $display("Stimulus table holds %0d entries instead of %0d", prog_len, NUM_ENTRIES);
            stop_failed();
        end

        repeat (RESET_CYCLES) @(negedge clk);
        // Reset values, before any free-running edge
        check_value("wb_ack_o", 64'(wb_ack_o), 64'd0);
        check_value("res_valid_o", 64'(res_valid_o), 64'd0);
        rst_n = 1'b0;
        @(negedge clk);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            rand_mode <= prog_rand[i];  // Seen by the monitor from the next edge on
            model_step(prog_inst[i], prog_ill[i]);
            wb_write(64'h8000_0000 + 64'(i * 4), prog_inst[i]);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;

        wait (checked_count == NUM_ENTRIES);
        repeat (8) @(negedge clk);  // Catch a duplicated result
        @(posedge clk);
        if (checked_count == NUM_ENTRIES && exp_rd_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1);
        end
    end

endmodule

// ==== project.f ====
+incdir+include
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/id_ex_if.sv
source/decode_stage.sv
source/id_ex_reg.sv
source/execute_stage.sv
source/core_top.sv
test/clk_gen.sv
test/tb_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module tb_top \
		-Mdir obj_dir -o sim

run: compile
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
